// File: source/joiner_cfg_pkg.sv
package joiner_cfg_pkg;

  // Lanes in the batch and input streams per lane
  localparam int BATCH    = 2;
  localparam int CHANNELS = 2;

  // Stream word and byte enables
  localparam int DATA_WIDTH = 16;
  localparam int KEEP_WIDTH = (DATA_WIDTH + 7) / 8;

  // Index widths, kept at least one bit wide
  localparam int LANE_W = (BATCH > 1) ? $clog2(BATCH) : 1;
  localparam int CH_W   = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

  // Longest joined packet a lane may emit
  localparam int MAX_BEATS = 32;
  // Counter must hold one past the limit
  localparam int BEAT_W    = $clog2(MAX_BEATS + 1);

endpackage

// File: source/joiner_stream_pkg.sv
package joiner_stream_pkg;

  import joiner_cfg_pkg::*;

  // One beat on a stream port, handshake travels beside it
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [KEEP_WIDTH-1:0] keep;
    logic                  last;
  } stream_beat_t;

  // Merged output beat tagged with the source lane
  typedef struct packed {
    stream_beat_t      beat;
    logic [LANE_W-1:0] tid;
  } out_beat_t;

  // Per-lane report to the batch control
  typedef struct packed {
    logic busy;
    logic done;
    logic error;
  } lane_status_t;

  // Operation request, sampled on operation_start
  typedef struct packed {
    logic [CHANNELS-1:0] use_channels;
    logic [BATCH-1:0]    use_batch;
  } op_config_t;

endpackage

// File: source/joiner_sequencer.sv
`timescale 1ns/1ps

module joiner_sequencer
  import joiner_cfg_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  logic [CHANNELS-1:0] use_channels,
  input  logic                abort,
  input  logic                lock,
  input  logic                beat_done,
  input  logic                beat_last,
  output logic [CH_W-1:0]     cur_channel,
  output logic                final_channel,
  output logic                busy,
  output logic                done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_HOLD,
    ST_LOCKED
  } state_t;

  state_t          state;
  logic [CH_W-1:0] first_ch;
  logic [CH_W-1:0] last_ch;
  logic [CH_W-1:0] next_ch;

  // Scan downwards so the lowest match is written last
  always_comb begin
    first_ch = '0;
    next_ch  = cur_channel;
    for (int i = CHANNELS - 1; i >= 0; i--) begin
      if (use_channels[i]) begin
        first_ch = CH_W'(i);
        if (CH_W'(i) > cur_channel) begin
          next_ch = CH_W'(i);
        end
      end
    end
  end

  // Highest enabled channel carries the joined tlast
  always_comb begin
    last_ch = '0;
    for (int i = 0; i < CHANNELS; i++) begin
      if (use_channels[i]) begin
        last_ch = CH_W'(i);
      end
    end
  end

  assign final_channel = (cur_channel == last_ch);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ST_IDLE;
      cur_channel <= '0;
    end else if (abort) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state       <= ST_RUN;
            cur_channel <= first_ch;
          end
        end
        ST_RUN: begin
          // Step on each packet end, stop after the final channel
          if (beat_done && beat_last) begin
            if (final_channel) begin
              state <= ST_HOLD;
            end else begin
              cur_channel <= next_ch;
            end
          end
        end
        ST_HOLD: state <= lock ? ST_LOCKED : ST_IDLE;
        ST_LOCKED: begin
          if (!lock) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign busy = (state == ST_RUN);
  // Single-cycle done, lock keeps the lane parked afterwards
  assign done = (state == ST_HOLD);

endmodule

// File: source/beat_counter.sv
`timescale 1ns/1ps

module beat_counter
  import joiner_cfg_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic clear,
  input  logic count,
  output logic overflow
);

  logic [BEAT_W-1:0] beats;

  // An overflow aborts the lane at once, so the count never goes past MAX_BEATS + 1
  always_ff @(posedge clk) begin
    if (rst) begin
      beats <= '0;
    end else if (clear) begin
      beats <= '0;
    end else if (count) begin
      beats <= beats + 1'b1;
    end
  end

  // Raised once the joined packet has passed the limit
  assign overflow = (beats > BEAT_W'(MAX_BEATS));

endmodule

// File: source/lane_joiner.sv
`timescale 1ns/1ps

module lane_joiner
  import joiner_cfg_pkg::*;
  import joiner_stream_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start,
  input  logic [CHANNELS-1:0]         use_channels,
  input  logic                        abort,
  input  logic                        lock,
  input  stream_beat_t [CHANNELS-1:0] s_beat,
  input  logic [CHANNELS-1:0]         s_valid,
  output logic [CHANNELS-1:0]         s_ready,
  output stream_beat_t                lane_beat,
  output logic                        lane_valid,
  input  logic                        lane_ready,
  output lane_status_t                status
);

  logic [CH_W-1:0] cur_channel;
  logic            final_channel;
  logic            running;
  logic            lane_done;
  logic            overflow;
  logic            beat_done;
  stream_beat_t    cur_beat;

  joiner_sequencer u_sequencer (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .use_channels  (use_channels),
    .abort         (abort),
    .lock          (lock),
    .beat_done     (beat_done),
    .beat_last     (cur_beat.last),
    .cur_channel   (cur_channel),
    .final_channel (final_channel),
    .busy          (running),
    .done          (lane_done)
  );

  // Current channel only, no storage in the lane
  assign cur_beat   = s_beat[cur_channel];
  assign lane_valid = running && s_valid[cur_channel];
  assign beat_done  = lane_valid && lane_ready;

  // Inner packet ends are hidden from the joined stream
  always_comb begin
    lane_beat      = cur_beat;
    lane_beat.last = cur_beat.last && final_channel;
  end

  always_comb begin
    s_ready              = '0;
    s_ready[cur_channel] = running && lane_ready;
  end

  // Length is checked over the whole joined packet
  beat_counter u_beat_counter (
    .clk      (clk),
    .rst      (rst),
    .clear    (start || abort),
    .count    (beat_done),
    .overflow (overflow)
  );

  assign status = '{busy: running, done: lane_done, error: overflow};

endmodule

// File: source/batch_arbiter.sv
`timescale 1ns/1ps

module batch_arbiter
  import joiner_cfg_pkg::*;
  import joiner_stream_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  stream_beat_t [BATCH-1:0] lane_beat,
  input  logic [BATCH-1:0]         lane_valid,
  output logic [BATCH-1:0]         lane_ready,
  output out_beat_t                m_beat,
  output logic                     m_valid,
  input  logic                     m_ready,
  input  logic                     abort
);

  logic              granted;
  logic [LANE_W-1:0] grant_lane;
  logic [LANE_W-1:0] pick_lane;
  logic              pick_valid;
  logic              release_grant;

  // Fixed priority, lane 0 wins
  always_comb begin
    pick_lane  = '0;
    pick_valid = 1'b0;
    for (int i = BATCH - 1; i >= 0; i--) begin
      if (lane_valid[i]) begin
        pick_lane  = LANE_W'(i);
        pick_valid = 1'b1;
      end
    end
  end

  // Granted lane passes straight through
  assign m_valid = granted && lane_valid[grant_lane];
  assign m_beat  = '{beat: lane_beat[grant_lane], tid: grant_lane};

  always_comb begin
    lane_ready             = '0;
    lane_ready[grant_lane] = granted && m_ready;
  end

  assign release_grant = m_valid && m_ready && lane_beat[grant_lane].last;

  // Grant is held for a whole packet so packets never interleave
  always_ff @(posedge clk) begin
    if (rst) begin
      granted    <= 1'b0;
      grant_lane <= '0;
    end else if (abort) begin
      granted <= 1'b0;
    end else if (granted) begin
      if (release_grant) begin
        granted <= 1'b0;
      end
    end else if (pick_valid) begin
      granted    <= 1'b1;
      grant_lane <= pick_lane;
    end
  end

endmodule

// File: source/batch_joiner_top.sv
`timescale 1ns/1ps

module batch_joiner_top
  import joiner_cfg_pkg::*;
  import joiner_stream_pkg::*;
(
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    operation_start,
  input  op_config_t                              op_cfg,
  input  logic                                    interrupt,
  input  stream_beat_t [BATCH-1:0][CHANNELS-1:0]  s_beat,
  input  logic [BATCH-1:0][CHANNELS-1:0]          s_valid,
  output logic [BATCH-1:0][CHANNELS-1:0]          s_ready,
  output out_beat_t                               m_beat,
  output logic                                    m_valid,
  input  logic                                    m_ready,
  output logic                                    operation_busy,
  output logic                                    operation_complete,
  output logic                                    operation_error,
  output logic                                    transmission
);

  logic [CHANNELS-1:0]      use_channels_reg;
  logic [BATCH-1:0]         pending;
  logic [BATCH-1:0]         completed;
  logic [BATCH-1:0]         pending_next;
  logic [BATCH-1:0]         completed_next;
  logic [BATCH-1:0]         lane_start;
  logic [BATCH-1:0]         lane_lock;
  logic [BATCH-1:0]         lane_busy;
  logic [BATCH-1:0]         lane_done;
  logic [BATCH-1:0]         lane_error;
  lane_status_t [BATCH-1:0] lane_status;
  stream_beat_t [BATCH-1:0] lane_beat;
  logic [BATCH-1:0]         lane_valid;
  logic [BATCH-1:0]         lane_ready;
  logic                     bad_config;
  logic                     start_ok;
  logic                     all_done;
  logic                     error_detect;

  assign bad_config = (op_cfg.use_batch == '0) || (op_cfg.use_channels == '0);
  assign start_ok   = operation_start && !operation_busy && !bad_config;

  assign pending_next   = pending & ~lane_done;
  assign completed_next = completed | lane_done;
  assign all_done = operation_busy && (pending_next == '0) && (lane_busy == '0);

  // Finished lanes wait until the slowest enabled lane is through
  assign lane_lock = completed_next & {BATCH{operation_busy && (pending_next != '0)}};

  // Also used as the lane and arbiter abort
  assign error_detect = (operation_busy && (interrupt || (lane_error != '0))) ||
                        (operation_start && !operation_busy && bad_config);

  always_ff @(posedge clk) begin
    if (rst) begin
      operation_busy     <= 1'b0;
      operation_complete <= 1'b0;
      operation_error    <= 1'b0;
      pending            <= '0;
      completed          <= '0;
      lane_start         <= '0;
      use_channels_reg   <= '0;
    end else begin
      operation_complete <= all_done && !error_detect;
      operation_error    <= error_detect;
      // Lanes start one cycle late, once the channel mask is latched
      lane_start         <= start_ok ? op_cfg.use_batch : '0;
      if (error_detect) begin
        operation_busy <= 1'b0;
        pending        <= '0;
        completed      <= '0;
      end else if (start_ok) begin
        operation_busy   <= 1'b1;
        pending          <= op_cfg.use_batch;
        completed        <= '0;
        use_channels_reg <= op_cfg.use_channels;
      end else if (operation_busy) begin
        pending   <= pending_next;
        completed <= completed_next;
        if (all_done) begin
          operation_busy <= 1'b0;
        end
      end
    end
  end

  for (genvar b = 0; b < BATCH; b++) begin : g_lane
    lane_joiner u_lane (
      .clk          (clk),
      .rst          (rst),
      .start        (lane_start[b]),
      .use_channels (use_channels_reg),
      .abort        (error_detect),
      .lock         (lane_lock[b]),
      .s_beat       (s_beat[b]),
      .s_valid      (s_valid[b]),
      .s_ready      (s_ready[b]),
      .lane_beat    (lane_beat[b]),
      .lane_valid   (lane_valid[b]),
      .lane_ready   (lane_ready[b]),
      .status       (lane_status[b])
    );

    assign lane_busy[b]  = lane_status[b].busy;
    assign lane_done[b]  = lane_status[b].done;
    assign lane_error[b] = lane_status[b].error;
  end

  batch_arbiter u_arbiter (
    .clk        (clk),
    .rst        (rst),
    .lane_beat  (lane_beat),
    .lane_valid (lane_valid),
    .lane_ready (lane_ready),
    .m_beat     (m_beat),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .abort      (error_detect)
  );

  assign transmission = m_valid && m_ready;

endmodule

// File: tests/joiner_checks.svh
`ifndef JOINER_CHECKS_SVH
`define JOINER_CHECKS_SVH

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
  return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

// Beat i of the source packet on lane b, channel c
function automatic stream_beat_t make_beat(input logic [DATA_WIDTH-1:0] seed,
                                           input int b, input int c, input int i, input int len);
  stream_beat_t beat;
  beat.data = seed + DATA_WIDTH'(b * 'h1000 + c * 'h100 + i);
  beat.keep = (i == len - 1) ? KEEP_WIDTH'(1) : {KEEP_WIDTH{1'b1}};
  beat.last = (i == len - 1);
  return beat;
endfunction

// Joined packet per lane, tlast only at the end of the highest enabled channel
task automatic build_expected(input int t);
  int        last_ch;
  out_beat_t ob;
  last_ch = -1;
  for (int c = 0; c < CHANNELS; c++) begin
    if (t_ch[t][c]) begin
      last_ch = c;
    end
  end
  for (int b = 0; b < BATCH; b++) begin
    exp_n[b] = 0;
    for (int c = 0; c < CHANNELS; c++) begin
      for (int i = 0; i < t_len[t][b][c]; i++) begin
        if (t_batch[t][b] && t_ch[t][c]) begin
          ob.beat      = make_beat(t_seed[t], b, c, i, t_len[t][b][c]);
          ob.beat.last = ob.beat.last && (c == last_ch);
          ob.tid       = LANE_W'(b);
          exp_mem[b][exp_n[b]] = ob;
          exp_n[b]++;
        end
      end
    end
  end
endtask

task automatic check_beat(input name_t name, input int lane, input int idx,
                          input out_beat_t exp, input out_beat_t got);
  if (got !== exp) begin
    $display("Error: %0s lane %0d beat %0d expected %h actual %h", name, lane, idx, exp, got);
    test_errs++;
  end
endtask

task automatic check_status(input name_t name, input lane_status_t exp, input lane_status_t got);
  if (got !== exp) begin
    $display("Error: %0s busy/done/error expected %b actual %b", name, exp, got);
    test_errs++;
  end
endtask

task automatic check_count(input name_t name, input int lane, input int exp, input int got);
  if (got != exp) begin
    $display("Error: %0s lane %0d beat count expected %0d actual %0d", name, lane, exp, got);
    test_errs++;
  end
endtask

`endif

// File: tests/joiner_tb.sv
`timescale 1ns/1ps

module joiner_tb
  import joiner_cfg_pkg::*;
  import joiner_stream_pkg::*;
();

  localparam int MAX_TESTS = 32;
  localparam int MEM_DEPTH = 64;

  typedef logic [8*24-1:0] name_t;

  logic                                   clk;
  logic                                   rst;
  logic                                   operation_start;
  op_config_t                             op_cfg;
  logic                                   interrupt;
  stream_beat_t [BATCH-1:0][CHANNELS-1:0] s_beat = '0;
  logic [BATCH-1:0][CHANNELS-1:0]         s_valid = '0;
  logic [BATCH-1:0][CHANNELS-1:0]         s_ready;
  out_beat_t                              m_beat;
  logic                                   m_valid;
  logic                                   m_ready = 1'b0;
  logic                                   operation_busy;
  logic                                   operation_complete;
  logic                                   operation_error;
  logic                                   transmission;

  // Trace contents per test
  name_t                 t_name [MAX_TESTS];
  logic [CHANNELS-1:0]   t_ch [MAX_TESTS];
  logic [BATCH-1:0]      t_batch [MAX_TESTS];
  int                    t_len [MAX_TESTS][BATCH][CHANNELS];
  logic [DATA_WIDTH-1:0] t_seed [MAX_TESTS];
  int                    t_irq [MAX_TESTS];
  int                    t_stall [MAX_TESTS];
  int                    t_expect [MAX_TESTS];
  int                    n_tests;

  logic                  drv_on = 1'b0;
  logic                  stall_on = 1'b0;
  int                    cur_len [BATCH][CHANNELS];
  logic [DATA_WIDTH-1:0] cur_seed;
  int                    beat_idx [BATCH][CHANNELS];
  logic [15:0]           lfsr = 16'd28;

  out_beat_t         exp_mem [BATCH][MEM_DEPTH];
  out_beat_t         got_mem [BATCH][MEM_DEPTH];
  int                exp_n [BATCH];
  int                got_n [BATCH];
  int                complete_cnt;
  int                error_cnt;
  bit                in_packet;
  logic [LANE_W-1:0] packet_tid;
  bit                interleaved;
  bit                ready_leak;
  bit                tx_mismatch;

  int test_errs;
  int pass_count = 0;
  int fail_count = 0;
  int cycle_count;
  int cycle_limit = 0;

  `include "joiner_checks.svh"

  batch_joiner_top u_dut (
    .clk                (clk),
    .rst                (rst),
    .operation_start    (operation_start),
    .op_cfg             (op_cfg),
    .interrupt          (interrupt),
    .s_beat             (s_beat),
    .s_valid            (s_valid),
    .s_ready            (s_ready),
    .m_beat             (m_beat),
    .m_valid            (m_valid),
    .m_ready            (m_ready),
    .operation_busy     (operation_busy),
    .operation_complete (operation_complete),
    .operation_error    (operation_error),
    .transmission       (transmission)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // One packet per channel with valid held until accepted
  always @(posedge clk) begin
    for (int b = 0; b < BATCH; b++) begin
      for (int c = 0; c < CHANNELS; c++) begin
        if (!drv_on) begin
          s_valid[b][c] <= 1'b0;
          beat_idx[b][c] = 0;
        end else begin
          if (s_valid[b][c] && s_ready[b][c]) begin
            beat_idx[b][c]++;
          end
          if (beat_idx[b][c] < cur_len[b][c]) begin
            s_valid[b][c] <= 1'b1;
            s_beat[b][c]  <= make_beat(cur_seed, b, c, beat_idx[b][c], cur_len[b][c]);
          end else begin
            s_valid[b][c] <= 1'b0;
          end
        end
      end
    end
  end

  // Sink back-pressure
  always @(posedge clk) begin
    if (stall_on) begin
      lfsr = lfsr_next(lfsr);
      m_ready <= lfsr[0];
    end else begin
      m_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    if (m_valid && m_ready) begin
      if (in_packet && m_beat.tid != packet_tid) begin
        interleaved = 1'b1;
      end
      if (!in_packet) begin
        packet_tid = m_beat.tid;
      end
      in_packet = !m_beat.beat.last;
      if (got_n[m_beat.tid] < MEM_DEPTH) begin
        got_mem[m_beat.tid][got_n[m_beat.tid]] = m_beat;
      end
      got_n[m_beat.tid]++;
    end
    if (transmission != (m_valid && m_ready)) begin
      tx_mismatch = 1'b1;
    end
    if (operation_complete) begin
      complete_cnt++;
    end
    if (operation_error) begin
      error_cnt++;
    end
    for (int b = 0; b < BATCH; b++) begin
      for (int c = 0; c < CHANNELS; c++) begin
        if (s_ready[b][c] && !(op_cfg.use_batch[b] && op_cfg.use_channels[c])) begin
          ready_leak = 1'b1;
        end
      end
    end
  end

  initial begin
    cycle_count = 0;
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run hung: no end of operation within %0d cycles", cycle_limit);
    $display("Test failed");
    $finish;
  end

  task automatic read_trace();
    int                    fd;
    int                    rc;
    int                    total;
    logic [8*128-1:0]      line;
    name_t                 name;
    logic [CHANNELS-1:0]   ch;
    logic [BATCH-1:0]      bt;
    int                    l00;
    int                    l01;
    int                    l10;
    int                    l11;
    logic [DATA_WIDTH-1:0] seed;
    int                    irq;
    int                    stall;
    int                    exp_err;
    n_tests = 0;
    total   = 0;
    fd = $fopen("tests/joiner_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the trace file tests/joiner_trace.txt");
    end else begin
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
        line = '0;
        rc = $fgets(line, fd);
        // Comment and blank lines do not yield all eleven fields
        rc = $sscanf(line, "%s %b %b %d %d %d %d %h %d %d %d", name, ch, bt,
                     l00, l01, l10, l11, seed, irq, stall, exp_err);
        if (rc == 11) begin
          t_name[n_tests]      = name;
          t_ch[n_tests]        = ch;
          t_batch[n_tests]     = bt;
          t_len[n_tests][0][0] = l00;
          t_len[n_tests][0][1] = l01;
          t_len[n_tests][1][0] = l10;
          t_len[n_tests][1][1] = l11;
          t_seed[n_tests]      = seed;
          t_irq[n_tests]       = irq;
          t_stall[n_tests]     = stall;
          t_expect[n_tests]    = exp_err;
          total += l00 + l01 + l10 + l11;
          n_tests++;
        end
      end
      $fclose(fd);
    end
    cycle_limit = total * 8 + 200;
  endtask

  task automatic run_test(input int t);
    lane_status_t exp_st;
    lane_status_t got_st;
    lane_status_t start_exp;
    lane_status_t start_st;
    int           cyc;
    int           n;
    bit           cfg_ok;
    bit           exact;
    name_t        name;
    name   = t_name[t];
    cfg_ok = (t_batch[t] != '0) && (t_ch[t] != '0);
    exact  = (t_expect[t] == 0) || !cfg_ok;
    test_errs = 0;
    for (int b = 0; b < BATCH; b++) begin
      got_n[b] = 0;
      for (int c = 0; c < CHANNELS; c++) begin
        cur_len[b][c] = t_len[t][b][c];
      end
    end
    cur_seed     = t_seed[t];
    complete_cnt = 0;
    error_cnt    = 0;
    in_packet    = 1'b0;
    interleaved  = 1'b0;
    ready_leak   = 1'b0;
    tx_mismatch  = 1'b0;
    build_expected(t);

    @(posedge clk);
    op_cfg          <= '{use_channels: t_ch[t], use_batch: t_batch[t]};
    operation_start <= 1'b1;
    drv_on          <= 1'b1;
    stall_on        <= (t_stall[t] != 0);
    @(posedge clk);
    operation_start <= 1'b0;
    cyc = 1;
    @(negedge clk);

    // Busy rises, or a bad request errors, one cycle after the start
    start_exp = '{busy: cfg_ok, done: 1'b0, error: !cfg_ok};
    start_st  = '{busy: operation_busy, done: operation_complete, error: operation_error};
    check_status(name, start_exp, start_st);

    while (complete_cnt == 0 && error_cnt == 0) begin
      @(posedge clk);
      cyc++;
      interrupt <= (t_irq[t] != 0) && (cyc == t_irq[t]);
      @(negedge clk);
    end
    got_st = '{busy: operation_busy, done: (complete_cnt != 0), error: (error_cnt != 0)};
    exp_st = '{busy: 1'b0, done: (t_expect[t] == 0), error: (t_expect[t] != 0)};

    // Let any stray pulse show up before judging
    @(posedge clk);
    interrupt <= 1'b0;
    drv_on    <= 1'b0;
    stall_on  <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);

    check_status(name, exp_st, got_st);
    for (int b = 0; b < BATCH; b++) begin
      n = (got_n[b] < exp_n[b]) ? got_n[b] : exp_n[b];
      for (int i = 0; i < n; i++) begin
        check_beat(name, b, i, exp_mem[b][i], got_mem[b][i]);
      end
      if (exact) begin
        check_count(name, b, exp_n[b], got_n[b]);
      end else if (got_n[b] > exp_n[b]) begin
        $display("%0s: lane %0d sent more beats than its packets hold", name, b);
        test_errs++;
      end
    end
    if (complete_cnt > 1 || error_cnt > 1) begin
      $display("%0s: end of operation was signalled more than once", name);
      test_errs++;
    end
    if (ready_leak) begin
      $display("%0s: a disabled channel saw s_ready high", name);
      test_errs++;
    end
    if (interleaved) begin
      $display("%0s: beats of two lanes were mixed inside one output packet", name);
      test_errs++;
    end
    if (tx_mismatch) begin
      $display("%0s: transmission did not follow the output handshake", name);
      test_errs++;
    end
    $display("%0s: %0s", name, (test_errs == 0) ? "pass" : "FAIL");
    if (test_errs == 0) begin
      pass_count++;
    end else begin
      fail_count++;
    end
  endtask

  initial begin
    rst             <= 1'b1;
    operation_start <= 1'b0;
    op_cfg          <= '0;
    interrupt       <= 1'b0;
    read_trace();
    if (n_tests == 0) begin
      $display("No tests could be read from the trace file");
      $display("Test failed");
      $finish;
    end else begin
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      if (operation_busy || operation_complete || operation_error || transmission ||
          m_valid || (s_ready != '0)) begin
        $display("Outputs were not all low after reset");
        fail_count++;
      end
      for (int t = 0; t < n_tests; t++) begin
        run_test(t);
      end
      $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule

// File: compile.f
+incdir+tests
source/joiner_cfg_pkg.sv
source/joiner_stream_pkg.sv
source/joiner_sequencer.sv
source/beat_counter.sv
source/lane_joiner.sv
source/batch_arbiter.sv
source/batch_joiner_top.sv
tests/joiner_tb.sv

// File: tests/joiner_trace.txt
# name use_channels use_batch len_l0c0 len_l0c1 len_l1c0 len_l1c1 seed irq stall expect_error
# masks in binary, seed in hex, irq counts cycles after start (0 for none)
one_lane_join      11 01  3  4  5  2 1000 0 0 0
one_lane_stall     11 01  5  6  2  2 1200 0 1 0
lane1_only         11 10  2  2  4  3 2000 0 0 0
two_lanes          11 11  4  3  2  5 3000 0 0 0
two_lanes_stall    11 11  6  5  7  4 3400 0 1 0
single_beats       11 11  1  1  1  1 3800 0 1 0
skip_ch0           10 11  3  4  5  6 4000 0 0 0
skip_ch1_stall     01 11  7  2  3  5 4400 0 1 0
no_lanes           11 00  2  2  2  2 5000 0 0 1
no_channels        00 11  2  2  2  2 5400 0 0 1
interrupt_mid      11 11 12 12 12 12 6000 6 1 1
after_interrupt    11 11  3  3  3  3 6400 0 1 0
overlong_lane0     11 01 20 20  2  2 7000 0 0 1
overlong_lane1     11 11  3  3 18 18 7400 0 1 1
after_overlong     11 11  5  4  6  3 8000 0 0 0
at_limit_stall     11 11 16 16 16 16 8400 0 1 0
